// File: rtl/imageCorePkg.sv
`default_nettype none

package imageCorePkg;

	// Data word and instruction word
	typedef logic [31:0] wordT;
	typedef logic [31:0] instrT;

	// Register index, r0 always reads zero
	typedef logic [4:0] regIdxT;

	// Word address into either memory
	typedef logic [7:0] memAddrT;

	// Function field, instruction bits 31..28
	// Codes not listed here decode as no-operation
	typedef enum logic [3:0]
	{
		Sum          = 4'b0000,
		Subs         = 4'b0001,
		Mult         = 4'b0010,
		Load         = 4'b0100,
		Store        = 4'b0101,
		Gray         = 4'b1010,
		LoadAligned  = 4'b1011,
		StorePlusOne = 4'b1100,
		Halt         = 4'b1111
	} functT;

	typedef enum logic [2:0]
	{
		AluAdd,
		AluSub,
		AluMult,
		AluPass,
		AluGray
	} aluOpT;

	// Writeback source
	typedef enum logic [1:0]
	{
		WbAlu,
		WbMem,
		WbMemAligned
	} wbSelT;

	// APB byte offsets
	localparam logic [11:0] CtrlAddr    = 12'h000;
	localparam logic [11:0] StatusAddr  = 12'h004;
	localparam logic [11:0] RetiredAddr = 12'h008;
	localparam logic [11:0] ImemBase    = 12'h400;
	localparam logic [11:0] DmemBase    = 12'h800;

endpackage

`default_nettype wire

// File: rtl/controlUnit.sv
`timescale 1ns/10ps
`default_nettype none

module controlUnit
	import imageCorePkg::*;
(
	input  functT  funct,
	input  logic   immFlag,
	input  regIdxT rd,
	output aluOpT  aluOp,
	output logic   useImm,
	output logic   regWrite,
	output logic   memRead,
	output logic   memWrite,
	output logic   plusOne,
	output logic   storeImm,
	output wbSelT  wbSel,
	output regIdxT dest,
	output logic   isHalt
);

	always_comb
	begin
		// Everything idle unless a code below enables it
		aluOp    = AluPass;
		useImm   = 1'b0;
		regWrite = 1'b0;
		memRead  = 1'b0;
		memWrite = 1'b0;
		plusOne  = 1'b0;
		storeImm = 1'b0;
		wbSel    = WbAlu;
		isHalt   = 1'b0;
		case (funct)
			Sum, Subs, Mult, Gray:
			begin
				// Arithmetic, operand B may be the immediate
				aluOp    = (funct == Sum)  ? AluAdd :
				           (funct == Subs) ? AluSub :
				           (funct == Mult) ? AluMult : AluGray;
				useImm   = immFlag;
				regWrite = 1'b1;
			end
			Load, LoadAligned:
			begin
				// Address is A plus B or imm
				aluOp    = AluAdd;
				useImm   = immFlag;
				regWrite = 1'b1;
				memRead  = 1'b1;
				wbSel    = (funct == LoadAligned) ? WbMemAligned : WbMem;
			end
			Store, StorePlusOne:
			begin
				// Address is A alone
				aluOp    = AluPass;
				memWrite = 1'b1;
				storeImm = immFlag;
				plusOne  = (funct == StorePlusOne);
			end
			Halt:
				isHalt = 1'b1;
			default:
			begin
				// No-operation keeps the defaults
			end
		endcase
		// Non-writing ops carry r0 so they never look like a hazard
		dest = regWrite ? rd : '0;
	end

endmodule

`default_nettype wire

// File: rtl/fetchStage.sv
`timescale 1ns/10ps
`default_nettype none

module fetchStage
	import imageCorePkg::*;
#(
	parameter int ImemDepth = 256
)
(
	input  logic    clk,
	input  logic    reset,
	input  logic    run,
	input  logic    restart,
	input  logic    stall,
	input  logic    haltSeen,
	input  logic    imemWe,
	input  memAddrT imemAddr,
	input  wordT    imemWdata,
	output instrT   fetchInstr,
	output logic    fetchValid
);

	instrT   imem [0:ImemDepth-1];
	memAddrT pc;
	// Set once a halt has been decoded
	logic    stopped;
	logic    advance;

	assign advance = run & ~stall & ~restart;

	// Host loads the program while the core is idle
	always_ff @(posedge clk)
	begin
		if (imemWe)
			imem[imemAddr] <= imemWdata;
	end

	always_ff @(posedge clk)
	begin
		if (advance)
			fetchInstr <= imem[pc];
	end

	always_ff @(posedge clk)
	begin
		if (reset || restart)
		begin
			pc         <= '0;
			fetchValid <= 1'b0;
			stopped    <= 1'b0;
		end
		else if (advance)
		begin
			if (haltSeen || stopped)
			begin
				// PC frozen, only bubbles from here
				fetchValid <= 1'b0;
				stopped    <= 1'b1;
			end
			else
			begin
				fetchValid <= 1'b1;
				pc         <= pc + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/decodeStage.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStage
	import imageCorePkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   run,
	input  logic   restart,
	input  instrT  fetchInstr,
	input  logic   fetchValid,
	input  logic   regWe,
	input  regIdxT regAddr,
	input  wordT   regWdata,
	input  regIdxT exDest,
	input  logic   exRegWrite,
	input  logic   exValid,
	input  regIdxT memDest,
	input  logic   memRegWrite,
	input  logic   memValid,
	output logic   stall,
	output logic   haltSeen,
	output aluOpT  decAluOp,
	output logic   decUseImm,
	output logic   decRegWrite,
	output logic   decMemRead,
	output logic   decMemWrite,
	output logic   decPlusOne,
	output logic   decStoreImm,
	output wbSelT  decWbSel,
	output regIdxT decDest,
	output logic   decIsHalt,
	output wordT   operandA,
	output wordT   operandB,
	output wordT   imm,
	output logic   decValid
);

	wordT   regs [0:31];
	regIdxT srcA;
	regIdxT srcB;
	wordT   readA;
	wordT   readB;
	aluOpT  aluOpC;
	wbSelT  wbSelC;
	regIdxT destC;
	logic   useImmC;
	logic   regWriteC;
	logic   memReadC;
	logic   memWriteC;
	logic   plusOneC;
	logic   storeImmC;
	logic   isHaltC;
	logic   usesA;
	logic   usesB;
	logic   hazardA;
	logic   hazardB;

	assign srcA = fetchInstr[21:17];
	assign srcB = fetchInstr[16:12];

	controlUnit u_controlUnit
	(
		.funct    (functT'(fetchInstr[31:28])),
		.immFlag  (fetchInstr[27]),
		.rd       (fetchInstr[26:22]),
		.aluOp    (aluOpC),
		.useImm   (useImmC),
		.regWrite (regWriteC),
		.memRead  (memReadC),
		.memWrite (memWriteC),
		.plusOne  (plusOneC),
		.storeImm (storeImmC),
		.wbSel    (wbSelC),
		.dest     (destC),
		.isHalt   (isHaltC)
	);

	// Writeback from memory stage, r0 never written
	always_ff @(posedge clk)
	begin
		if (regWe && regAddr != '0)
			regs[regAddr] <= regWdata;
	end

	// Write-first read so the retiring result is seen this cycle
	assign readA = (srcA == '0) ? '0 : (regWe && regAddr == srcA) ? regWdata : regs[srcA];
	assign readB = (srcB == '0) ? '0 : (regWe && regAddr == srcB) ? regWdata : regs[srcB];

	// Which sources are actually read
	assign usesA = regWriteC | memWriteC;
	assign usesB = (regWriteC & ~useImmC) | (memWriteC & ~storeImmC);

	// Interlock against pending writers in execute and memory
	assign hazardA = (srcA != '0) &&
		((exValid && exRegWrite && exDest == srcA) ||
		 (memValid && memRegWrite && memDest == srcA));
	assign hazardB = (srcB != '0) &&
		((exValid && exRegWrite && exDest == srcB) ||
		 (memValid && memRegWrite && memDest == srcB));

	assign stall    = fetchValid & ((usesA & hazardA) | (usesB & hazardB));
	assign haltSeen = fetchValid & isHaltC;

	always_ff @(posedge clk)
	begin
		if (reset || restart)
			decValid <= 1'b0;
		else if (run)
			decValid <= fetchValid & ~stall;
	end

	// Control word and operands, qualified by decValid
	always_ff @(posedge clk)
	begin
		if (run)
		begin
			decAluOp    <= aluOpC;
			decUseImm   <= useImmC;
			decRegWrite <= regWriteC;
			decMemRead  <= memReadC;
			decMemWrite <= memWriteC;
			decPlusOne  <= plusOneC;
			decStoreImm <= storeImmC;
			decWbSel    <= wbSelC;
			decDest     <= destC;
			decIsHalt   <= isHaltC;
			operandA    <= readA;
			operandB    <= readB;
			imm         <= {20'd0, fetchInstr[11:0]};
		end
	end

endmodule

`default_nettype wire

// File: rtl/executeStage.sv
`timescale 1ns/10ps
`default_nettype none

module executeStage
	import imageCorePkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    run,
	input  logic    restart,
	input  aluOpT   decAluOp,
	input  logic    decUseImm,
	input  logic    decRegWrite,
	input  logic    decMemRead,
	input  logic    decMemWrite,
	input  logic    decPlusOne,
	input  logic    decStoreImm,
	input  wbSelT   decWbSel,
	input  regIdxT  decDest,
	input  logic    decIsHalt,
	input  wordT    operandA,
	input  wordT    operandB,
	input  wordT    imm,
	input  logic    decValid,
	output regIdxT  exDest,
	output logic    exRegWrite,
	output logic    exValid,
	output memAddrT dmemAddr,
	output wordT    aluResult,
	output wordT    storeData,
	output logic    xmRegWrite,
	output logic    xmMemWrite,
	output wbSelT   xmWbSel,
	output regIdxT  xmDest,
	output logic    xmIsHalt,
	output logic    xmValid
);

	wordT opB;
	wordT greySum;
	wordT aluNext;
	wordT storeNext;

	// Hazard view of the instruction now in execute
	assign exDest     = decDest;
	assign exRegWrite = decRegWrite;
	assign exValid    = decValid;

	assign opB = decUseImm ? imm : operandB;

	// Luma weights 77/150/29 on 0x00RRGGBB
	assign greySum = 32'd77 * {24'd0, operandA[23:16]} +
	                 32'd150 * {24'd0, operandA[15:8]} +
	                 32'd29 * {24'd0, operandA[7:0]};

	always_comb
	begin
		case (decAluOp)
			AluAdd:  aluNext = operandA + opB;
			AluSub:  aluNext = operandA - opB;
			// Low 32 bits of the product
			AluMult: aluNext = operandA * opB;
			AluGray: aluNext = greySum >> 8;
			default: aluNext = operandA;
		endcase
	end

	// Aligned load drops the two low word address bits
	assign dmemAddr = (decMemRead && decWbSel == WbMemAligned) ?
	                  {aluNext[7:2], 2'b00} : aluNext[7:0];

	assign storeNext = (decStoreImm ? imm : operandB) + {31'd0, decPlusOne};

	always_ff @(posedge clk)
	begin
		if (reset || restart)
			xmValid <= 1'b0;
		else if (run)
			xmValid <= decValid;
	end

	always_ff @(posedge clk)
	begin
		if (run)
		begin
			aluResult  <= aluNext;
			storeData  <= storeNext;
			xmRegWrite <= decRegWrite;
			xmMemWrite <= decMemWrite;
			xmWbSel    <= decWbSel;
			xmDest     <= decDest;
			xmIsHalt   <= decIsHalt;
		end
	end

endmodule

`default_nettype wire

// File: rtl/memoryStage.sv
`timescale 1ns/10ps
`default_nettype none

module memoryStage
	import imageCorePkg::*;
#(
	parameter int DmemDepth = 256
)
(
	input  logic    clk,
	input  logic    reset,
	input  logic    run,
	input  logic    restart,
	input  wordT    aluResult,
	input  wordT    storeData,
	input  logic    xmRegWrite,
	input  logic    xmMemWrite,
	input  wbSelT   xmWbSel,
	input  regIdxT  xmDest,
	input  logic    xmIsHalt,
	input  logic    xmValid,
	input  memAddrT dmemAddr,
	input  logic    dmemHostEn,
	input  logic    dmemHostWe,
	input  memAddrT dmemHostAddr,
	input  wordT    dmemHostWdata,
	output wordT    dmemHostRdata,
	output logic    regWe,
	output regIdxT  regAddr,
	output wordT    regWdata,
	output regIdxT  memDest,
	output logic    memRegWrite,
	output logic    memValid,
	output logic    retirePulse,
	output logic    haltPulse
);

	wordT    dmem [0:DmemDepth-1];
	wordT    rdData;
	memAddrT stAddr;
	memAddrT rdAddr;
	memAddrT wrAddr;
	wordT    wrData;
	logic    active;
	logic    memWe;
	logic    memRe;

	assign active = run & ~restart;

	// Host port only reaches the memory while the core is stopped
	assign rdAddr = dmemHostEn ? dmemHostAddr : dmemAddr;
	assign wrAddr = dmemHostEn ? dmemHostAddr : stAddr;
	assign wrData = dmemHostEn ? dmemHostWdata : storeData;
	assign memWe  = (active & xmValid & xmMemWrite) | (dmemHostEn & dmemHostWe);
	assign memRe  = active | dmemHostEn;

	// Store address travels with the instruction into memory
	always_ff @(posedge clk)
	begin
		if (active)
			stAddr <= dmemAddr;
	end

	// Load in execute sees a store leaving memory on the same edge
	always_ff @(posedge clk)
	begin
		// Contents survive a reset
		if (memWe && !reset)
			dmem[wrAddr] <= wrData;
		if (memRe)
			rdData <= (memWe && wrAddr == rdAddr) ? wrData : dmem[rdAddr];
	end

	assign dmemHostRdata = rdData;

	// Both load flavours return the word read
	assign regWdata = (xmWbSel == WbAlu) ? aluResult : rdData;
	assign regAddr  = xmDest;
	assign regWe    = active & xmValid & xmRegWrite;

	assign memDest     = xmDest;
	assign memRegWrite = xmRegWrite;
	assign memValid    = xmValid;

	// No-operations count as retired too
	assign retirePulse = active & xmValid & ~xmIsHalt;
	assign haltPulse   = active & xmValid & xmIsHalt;

endmodule

`default_nettype wire

// File: rtl/apbHostPort.sv
`timescale 1ns/10ps
`default_nettype none

module apbHostPort
	import imageCorePkg::*;
#(
	parameter int ImemDepth = 256,
	parameter int DmemDepth = 256
)
(
	input  logic        clk,
	input  logic        reset,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [11:0] paddr,
	input  wordT        pwdata,
	output wordT        prdata,
	output logic        pready,
	output logic        pslverr,
	input  logic        retirePulse,
	input  logic        haltPulse,
	output logic        run,
	output logic        restart,
	output logic        imemWe,
	output memAddrT     imemAddr,
	output wordT        imemWdata,
	output logic        dmemHostEn,
	output logic        dmemHostWe,
	output memAddrT     dmemHostAddr,
	output wordT        dmemHostWdata,
	input  wordT        dmemHostRdata
);

	logic access;
	logic ctrlHit;
	logic statusHit;
	logic retiredHit;
	logic imemHit;
	logic dmemHit;
	logic dmemRead;
	logic accErr;
	// High in the second cycle of a data memory read
	logic waitDone;
	logic halted;
	wordT retireCount;

	assign access     = psel & penable;
	assign ctrlHit    = (paddr == CtrlAddr);
	assign statusHit  = (paddr == StatusAddr);
	assign retiredHit = (paddr == RetiredAddr);
	assign imemHit    = (paddr[11:10] == ImemBase[11:10]) && (int'(paddr[9:2]) < ImemDepth);
	assign dmemHit    = (paddr[11:10] == DmemBase[11:10]) && (int'(paddr[9:2]) < DmemDepth);

	// Memories are locked while the program runs
	assign accErr   = ~(ctrlHit | statusHit | retiredHit | imemHit | dmemHit) |
	                  ((imemHit | dmemHit) & run);
	assign dmemRead = dmemHit & ~pwrite & ~run;

	assign pready  = ~(dmemRead & ~waitDone);
	assign pslverr = access & pready & accErr;

	assign imemWe        = access & imemHit & pwrite & ~run;
	assign imemAddr      = paddr[9:2];
	assign imemWdata     = pwdata;
	assign dmemHostEn    = access & dmemHit & ~run & (pwrite | ~waitDone);
	assign dmemHostWe    = pwrite;
	assign dmemHostAddr  = paddr[9:2];
	assign dmemHostWdata = pwdata;

	// Instruction memory is write-only from the host
	always_comb
	begin
		if (ctrlHit)
			prdata = {31'd0, run};
		else if (statusHit)
			prdata = {31'd0, halted};
		else if (retiredHit)
			prdata = retireCount;
		else if (dmemHit)
			prdata = dmemHostRdata;
		else
			prdata = '0;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			waitDone <= 1'b0;
		else
			waitDone <= access & dmemRead & ~waitDone;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			run         <= 1'b0;
			restart     <= 1'b0;
			halted      <= 1'b0;
			retireCount <= '0;
		end
		else
		begin
			restart <= 1'b0;
			if (haltPulse)
			begin
				run    <= 1'b0;
				halted <= 1'b1;
			end
			// Host write wins over a halt in the same cycle
			if (access && pwrite && ctrlHit)
			begin
				run     <= pwdata[0];
				restart <= pwdata[0];
			end
			if (restart)
			begin
				halted      <= 1'b0;
				retireCount <= '0;
			end
			else if (retirePulse)
				retireCount <= retireCount + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/imageCore.sv
`timescale 1ns/10ps
`default_nettype none

module imageCore
	import imageCorePkg::*;
#(
	parameter int ImemDepth = 256,
	parameter int DmemDepth = 256
)
(
	input  logic        clk,
	input  logic        reset,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [11:0] paddr,
	input  wordT        pwdata,
	output wordT        prdata,
	output logic        pready,
	output logic        pslverr
);

	// Host side
	logic    run;
	logic    restart;
	logic    imemWe;
	memAddrT imemAddr;
	wordT    imemWdata;
	logic    dmemHostEn;
	logic    dmemHostWe;
	memAddrT dmemHostAddr;
	wordT    dmemHostWdata;
	wordT    dmemHostRdata;
	logic    retirePulse;
	logic    haltPulse;

	// Fetch to decode
	instrT   fetchInstr;
	logic    fetchValid;
	logic    stall;
	logic    haltSeen;

	// Decode to execute
	aluOpT   decAluOp;
	logic    decUseImm;
	logic    decRegWrite;
	logic    decMemRead;
	logic    decMemWrite;
	logic    decPlusOne;
	logic    decStoreImm;
	wbSelT   decWbSel;
	regIdxT  decDest;
	logic    decIsHalt;
	wordT    operandA;
	wordT    operandB;
	wordT    imm;
	logic    decValid;

	// Execute to memory
	regIdxT  exDest;
	logic    exRegWrite;
	logic    exValid;
	memAddrT dmemAddr;
	wordT    aluResult;
	wordT    storeData;
	logic    xmRegWrite;
	logic    xmMemWrite;
	wbSelT   xmWbSel;
	regIdxT  xmDest;
	logic    xmIsHalt;
	logic    xmValid;

	// Writeback and interlock feedback
	logic    regWe;
	regIdxT  regAddr;
	wordT    regWdata;
	regIdxT  memDest;
	logic    memRegWrite;
	logic    memValid;

	apbHostPort #(
		.ImemDepth (ImemDepth),
		.DmemDepth (DmemDepth)
	) u_apbHostPort (
		.clk           (clk),
		.reset         (reset),
		.psel          (psel),
		.penable       (penable),
		.pwrite        (pwrite),
		.paddr         (paddr),
		.pwdata        (pwdata),
		.prdata        (prdata),
		.pready        (pready),
		.pslverr       (pslverr),
		.retirePulse   (retirePulse),
		.haltPulse     (haltPulse),
		.run           (run),
		.restart       (restart),
		.imemWe        (imemWe),
		.imemAddr      (imemAddr),
		.imemWdata     (imemWdata),
		.dmemHostEn    (dmemHostEn),
		.dmemHostWe    (dmemHostWe),
		.dmemHostAddr  (dmemHostAddr),
		.dmemHostWdata (dmemHostWdata),
		.dmemHostRdata (dmemHostRdata)
	);

	fetchStage #(
		.ImemDepth (ImemDepth)
	) u_fetchStage (
		.clk        (clk),
		.reset      (reset),
		.run        (run),
		.restart    (restart),
		.stall      (stall),
		.haltSeen   (haltSeen),
		.imemWe     (imemWe),
		.imemAddr   (imemAddr),
		.imemWdata  (imemWdata),
		.fetchInstr (fetchInstr),
		.fetchValid (fetchValid)
	);

	decodeStage u_decodeStage (
		.clk         (clk),
		.reset       (reset),
		.run         (run),
		.restart     (restart),
		.fetchInstr  (fetchInstr),
		.fetchValid  (fetchValid),
		.regWe       (regWe),
		.regAddr     (regAddr),
		.regWdata    (regWdata),
		.exDest      (exDest),
		.exRegWrite  (exRegWrite),
		.exValid     (exValid),
		.memDest     (memDest),
		.memRegWrite (memRegWrite),
		.memValid    (memValid),
		.stall       (stall),
		.haltSeen    (haltSeen),
		.decAluOp    (decAluOp),
		.decUseImm   (decUseImm),
		.decRegWrite (decRegWrite),
		.decMemRead  (decMemRead),
		.decMemWrite (decMemWrite),
		.decPlusOne  (decPlusOne),
		.decStoreImm (decStoreImm),
		.decWbSel    (decWbSel),
		.decDest     (decDest),
		.decIsHalt   (decIsHalt),
		.operandA    (operandA),
		.operandB    (operandB),
		.imm         (imm),
		.decValid    (decValid)
	);

	executeStage u_executeStage (
		.clk         (clk),
		.reset       (reset),
		.run         (run),
		.restart     (restart),
		.decAluOp    (decAluOp),
		.decUseImm   (decUseImm),
		.decRegWrite (decRegWrite),
		.decMemRead  (decMemRead),
		.decMemWrite (decMemWrite),
		.decPlusOne  (decPlusOne),
		.decStoreImm (decStoreImm),
		.decWbSel    (decWbSel),
		.decDest     (decDest),
		.decIsHalt   (decIsHalt),
		.operandA    (operandA),
		.operandB    (operandB),
		.imm         (imm),
		.decValid    (decValid),
		.exDest      (exDest),
		.exRegWrite  (exRegWrite),
		.exValid     (exValid),
		.dmemAddr    (dmemAddr),
		.aluResult   (aluResult),
		.storeData   (storeData),
		.xmRegWrite  (xmRegWrite),
		.xmMemWrite  (xmMemWrite),
		.xmWbSel     (xmWbSel),
		.xmDest      (xmDest),
		.xmIsHalt    (xmIsHalt),
		.xmValid     (xmValid)
	);

	memoryStage #(
		.DmemDepth (DmemDepth)
	) u_memoryStage (
		.clk           (clk),
		.reset         (reset),
		.run           (run),
		.restart       (restart),
		.aluResult     (aluResult),
		.storeData     (storeData),
		.xmRegWrite    (xmRegWrite),
		.xmMemWrite    (xmMemWrite),
		.xmWbSel       (xmWbSel),
		.xmDest        (xmDest),
		.xmIsHalt      (xmIsHalt),
		.xmValid       (xmValid),
		.dmemAddr      (dmemAddr),
		.dmemHostEn    (dmemHostEn),
		.dmemHostWe    (dmemHostWe),
		.dmemHostAddr  (dmemHostAddr),
		.dmemHostWdata (dmemHostWdata),
		.dmemHostRdata (dmemHostRdata),
		.regWe         (regWe),
		.regAddr       (regAddr),
		.regWdata      (regWdata),
		.memDest       (memDest),
		.memRegWrite   (memRegWrite),
		.memValid      (memValid),
		.retirePulse   (retirePulse),
		.haltPulse     (haltPulse)
	);

endmodule

`default_nettype wire

// File: tests/imageCore_props.sv
`timescale 1ns/10ps
`default_nettype none

module imageCoreProps
(
	input logic        clk,
	input logic        reset,
	input logic        psel,
	input logic        penable,
	input logic        pready,
	input logic        pslverr,
	input logic        run,
	input logic        restart,
	input logic        stall,
	input logic        fetchValid,
	input logic [4:0]  srcA,
	input logic [31:0] operandA,
	input logic        xmValid,
	input logic        xmMemWrite
);

	// Wait state lasts one cycle and the transfer then ends without error
	oneWaitState: assert property (@(posedge clk) disable iff (reset)
		(psel && penable && !pready) |=> (pready && !pslverr))
		else $error("wait state not followed by a clean completion");

	runLowAfterReset: assert property (@(posedge clk)
		reset |=> !run)
		else $error("run set right after reset");

	// An r0 source reaches execute as zero whatever writeback targets
	r0StaysZero: assert property (@(posedge clk) disable iff (reset)
		(run && fetchValid && srcA == 5'd0) |=> operandA == 32'd0)
		else $error("register 0 reached execute nonzero");

	// Stalled slot reaches memory as a bubble that can not store
	stallGivesBubble: assert property (@(posedge clk) disable iff (reset)
		(run && !restart && xmValid && xmMemWrite) |->
			!$past(run && !restart && stall, 2))
		else $error("store issued from a stalled slot");

endmodule

bind imageCore imageCoreProps u_imageCoreProps
(
	.clk        (clk),
	.reset      (reset),
	.psel       (psel),
	.penable    (penable),
	.pready     (pready),
	.pslverr    (pslverr),
	.run        (run),
	.restart    (restart),
	.stall      (stall),
	.fetchValid (fetchValid),
	.srcA       (fetchInstr[21:17]),
	.operandA   (operandA),
	.xmValid    (xmValid),
	.xmMemWrite (xmMemWrite)
);

`default_nettype wire

// File: tests/imageCoreTb.sv
`timescale 1ns/10ps
`default_nettype none

module imageCoreTb
	import imageCorePkg::*;
;

	// Cycle budgets of tests 1 to 6
	localparam int BudgetCycles = 3000 + 1500 + 1500 + 1500 + 1500 + 2500;

	logic        clk;
	logic        reset;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [11:0] paddr;
	wordT        pwdata;
	wordT        prdata;
	logic        pready;
	logic        pslverr;

	int      mismatchCount;
	int      otherCount;
	logic [31:0] rngState;
	wordT    modelMem [0:255];
	wordT    modelRegs [0:31];
	instrT   prog [$];

	imageCore u_imageCore
	(
		.clk     (clk),
		.reset   (reset),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Watchdog at twice the summed budget
	initial
	begin
		#(BudgetCycles * 2 * 10);
		$display("watchdog expired, simulation took too long");
		$display("RESULT: FAIL");
		$finish;
	end

	function automatic logic [31:0] xorshift();
		logic [31:0] x;
		x = rngState;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rngState = x;
		return x;
	endfunction

	function automatic instrT encode(input logic [3:0] f, input logic i, input int rd,
		input int ra, input int rb, input int immv);
		return {f, i, 5'(rd), 5'(ra), 5'(rb), 12'(immv)};
	endfunction

	task automatic addInstr(input logic [3:0] f, input logic i, input int rd, input int ra,
		input int rb, input int immv);
		prog.push_back(encode(f, i, rd, ra, rb, immv));
	endtask

	// Address into r31 and then store of src
	task automatic storeTo(input int addr, input int src);
		addInstr(Sum, 1'b1, 31, 0, 0, addr);
		addInstr(Store, 1'b0, 0, 31, src, 0);
	endtask

	// APB transfer that waits on pready with a bound
	task automatic apbAccess(input logic wr, input logic [11:0] addr, input wordT data,
		input logic expectErr, output wordT rdata);
		int waits;
		waits = 0;
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		while (!pready && waits < 8)
		begin
			waits++;
			@(negedge clk);
		end
		assert (pready) else
		begin
			otherCount++;
			$display("APB transfer to %h never completed", addr);
		end
		assert (pslverr === expectErr) else
		begin
			mismatchCount++;
			$display("mismatch t=%0t pslverr addr %h got %b exp %b", $time, addr, pslverr,
				expectErr);
		end
		rdata = prdata;
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apbWrite(input logic [11:0] addr, input wordT data, input logic expectErr);
		wordT unused;
		apbAccess(1'b1, addr, data, expectErr, unused);
	endtask

	task automatic apbRead(input logic [11:0] addr, output wordT data, input logic expectErr);
		apbAccess(1'b0, addr, '0, expectErr, data);
	endtask

	task automatic checkValue(input string name, input wordT got, input wordT exp);
		assert (got === exp) else
		begin
			mismatchCount++;
			$display("mismatch t=%0t %s got %h exp %h", $time, name, got, exp);
		end
	endtask

	task automatic checkWord(input int addr);
		wordT got;
		apbRead(12'(DmemBase + addr * 4), got, 1'b0);
		checkValue($sformatf("dmem[%0d]", addr), got, modelMem[addr]);
	endtask

	task automatic dmemPut(input int addr, input wordT v);
		modelMem[addr] = v;
		apbWrite(12'(DmemBase + addr * 4), v, 1'b0);
	endtask

	task automatic loadProgram();
		foreach (prog[k])
			apbWrite(12'(ImemBase + k * 4), prog[k], 1'b0);
	endtask

	// Sequential reference executing one instruction at a time
	task automatic runModel(output int retired);
		instrT w;
		wordT  a;
		wordT  opB;
		wordT  immv;
		wordT  res;
		logic  wr;
		retired = 0;
		foreach (prog[pc])
		begin
			w    = prog[pc];
			a    = modelRegs[w[21:17]];
			immv = {20'd0, w[11:0]};
			opB  = w[27] ? immv : modelRegs[w[16:12]];
			wr   = 1'b1;
			if (w[31:28] == Halt)
				break;
			case (w[31:28])
				Sum:          res = a + opB;
				Subs:         res = a - opB;
				Mult:         res = a * opB;
				Gray:         res = (77 * a[23:16] + 150 * a[15:8] + 29 * a[7:0]) >> 8;
				Load:         res = modelMem[8'(a + opB)];
				LoadAligned:  res = modelMem[8'(a + opB) & 8'hFC];
				Store:        wr = 1'b0;
				StorePlusOne: wr = 1'b0;
				default:      wr = 1'b0;
			endcase
			if (w[31:28] == Store)
				modelMem[a[7:0]] = opB;
			if (w[31:28] == StorePlusOne)
				modelMem[a[7:0]] = opB + 1;
			if (wr && w[26:22] != 5'd0)
				modelRegs[w[26:22]] = res;
			retired++;
		end
	endtask

	task automatic runToHalt(input int expRetired);
		wordT st;
		int   polls;
		polls = 0;
		apbWrite(CtrlAddr, 32'd1, 1'b0);
		st = '0;
		while (!st[0] && polls < 300)
		begin
			apbRead(StatusAddr, st, 1'b0);
			polls++;
		end
		assert (st[0]) else
		begin
			otherCount++;
			$display("core did not halt");
		end
		apbRead(RetiredAddr, st, 1'b0);
		checkValue("retired", st, expRetired);
		apbRead(CtrlAddr, st, 1'b0);
		checkValue("ctrl", st, 32'd0);
	endtask

	task automatic runProgram();
		int exp;
		runModel(exp);
		loadProgram();
		runToHalt(exp);
		for (int k = 0; k < 64; k++)
			checkWord(k);
	endtask

	task automatic testResetApb();
		wordT v;
		apbRead(StatusAddr, v, 1'b0);
		checkValue("status", v, 32'd0);
		apbRead(CtrlAddr, v, 1'b0);
		checkValue("ctrl", v, 32'd0);
		apbRead(RetiredAddr, v, 1'b0);
		checkValue("retired", v, 32'd0);
		for (int k = 0; k < 256; k++)
			dmemPut(k, 32'h9E3779B9 * (k + 1));
		for (int k = 0; k < 256; k += 17)
			checkWord(k);
		apbWrite(12'h00C, 32'h1234, 1'b1);
		prog.delete();
		for (int k = 0; k < 40; k++)
			addInstr(4'b0011, 1'b0, 1, 2, 3, k);
		addInstr(Halt, 1'b0, 0, 0, 0, 0);
		loadProgram();
		apbWrite(CtrlAddr, 32'd1, 1'b0);
		apbRead(12'(DmemBase + 4), v, 1'b1);
		apbRead(StatusAddr, v, 1'b0);
		checkValue("status while running", v, 32'd0);
		runToHalt(40);
	endtask

	task automatic testArith();
		prog.delete();
		for (int k = 40; k < 48; k++)
			dmemPut(k, xorshift());
		addInstr(Load, 1'b1, 1, 0, 0, 40);
		addInstr(Load, 1'b1, 2, 0, 0, 41);
		addInstr(Sum, 1'b0, 3, 1, 2, 0);
		addInstr(Subs, 1'b0, 4, 1, 2, 0);
		addInstr(Mult, 1'b0, 5, 1, 2, 0);
		addInstr(Sum, 1'b1, 6, 1, 0, xorshift() & 32'hFFF);
		addInstr(Subs, 1'b1, 7, 2, 0, xorshift() & 32'hFFF);
		addInstr(Mult, 1'b1, 8, 1, 0, xorshift() & 32'hFFF);
		for (int k = 3; k <= 8; k++)
			storeTo(k - 3, k);
		addInstr(Halt, 1'b0, 0, 0, 0, 0);
		runProgram();
	endtask

	task automatic testInterlock();
		prog.delete();
		addInstr(Load, 1'b1, 1, 0, 0, 42);
		addInstr(Sum, 1'b0, 2, 1, 1, 0);
		addInstr(Mult, 1'b0, 3, 2, 1, 0);
		addInstr(Subs, 1'b0, 4, 3, 2, 0);
		addInstr(Sum, 1'b1, 5, 4, 0, 7);
		addInstr(Mult, 1'b0, 5, 5, 5, 0);
		storeTo(8, 5);
		storeTo(9, 4);
		// Result aimed at r0 must stay invisible to the readers behind it
		addInstr(Sum, 1'b1, 0, 0, 0, 12'h777);
		storeTo(10, 0);
		addInstr(Halt, 1'b0, 0, 0, 0, 0);
		runProgram();
	endtask

	task automatic testMemory();
		prog.delete();
		addInstr(Sum, 1'b1, 31, 0, 0, 20);
		addInstr(Store, 1'b1, 0, 31, 0, 12'h5A5);
		addInstr(Load, 1'b1, 1, 0, 0, 43);
		addInstr(Sum, 1'b1, 31, 0, 0, 21);
		addInstr(StorePlusOne, 1'b0, 0, 31, 1, 0);
		addInstr(Sum, 1'b1, 31, 0, 0, 22);
		addInstr(StorePlusOne, 1'b1, 0, 31, 0, 12'hFFF);
		// 45 + 2 lands on 47 and aligns down to 44
		addInstr(Sum, 1'b1, 2, 0, 0, 45);
		addInstr(LoadAligned, 1'b1, 3, 2, 0, 2);
		storeTo(23, 3);
		addInstr(Load, 1'b0, 4, 0, 2, 0);
		storeTo(24, 4);
		addInstr(Halt, 1'b0, 0, 0, 0, 0);
		runProgram();
	endtask

	task automatic testGray();
		prog.delete();
		for (int k = 0; k < 4; k++)
			dmemPut(48 + k, xorshift() & 32'h00FFFFFF);
		for (int k = 0; k < 4; k++)
		begin
			addInstr(Load, 1'b1, k + 1, 0, 0, 48 + k);
			addInstr(Gray, 1'b0, k + 5, k + 1, 0, 0);
			storeTo(25 + k, k + 5);
		end
		addInstr(Halt, 1'b0, 0, 0, 0, 0);
		runProgram();
	endtask

	task automatic testNopHalt();
		logic [3:0] nops [0:6];
		int         exp;
		nops = '{4'b0011, 4'b0110, 4'b0111, 4'b1000, 4'b1001, 4'b1101, 4'b1110};
		prog.delete();
		addInstr(Load, 1'b1, 1, 0, 0, 40);
		addInstr(Sum, 1'b1, 31, 0, 0, 31);
		addInstr(StorePlusOne, 1'b0, 0, 31, 1, 0);
		foreach (nops[k])
			addInstr(nops[k], xorshift() & 1, 9, 31, 1, xorshift() & 32'hFFF);
		addInstr(Halt, 1'b0, 0, 0, 0, 0);
		// Never runs since it sits behind the halt
		addInstr(Store, 1'b1, 0, 31, 0, 12'h123);
		runProgram();
		runModel(exp);
		runToHalt(exp);
		for (int k = 0; k < 64; k++)
			checkWord(k);
	endtask

	initial
	begin
		reset         = 1'b1;
		psel          = 1'b0;
		penable       = 1'b0;
		pwrite        = 1'b0;
		paddr         = '0;
		pwdata        = '0;
		mismatchCount = 0;
		otherCount    = 0;
		rngState      = 32'h34e04d1f;
		for (int k = 0; k < 32; k++)
			modelRegs[k] = '0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		testResetApb();
		testArith();
		testInterlock();
		testMemory();
		testGray();
		testNopHalt();
		$display("errors: %0d mismatches, %0d other", mismatchCount, otherCount);
		if (mismatchCount == 0 && otherCount == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
rtl/imageCorePkg.sv
rtl/controlUnit.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/apbHostPort.sv
rtl/imageCore.sv
tests/imageCore_props.sv
tests/imageCoreTb.sv

// File: Bender.yml
package:
  name: imageCore

sources:
  - rtl/imageCorePkg.sv
  - rtl/controlUnit.sv
  - rtl/fetchStage.sv
  - rtl/decodeStage.sv
  - rtl/executeStage.sv
  - rtl/memoryStage.sv
  - rtl/apbHostPort.sv
  - rtl/imageCore.sv
  - target: test
    files:
      - tests/imageCore_props.sv
      - tests/imageCoreTb.sv
